//--- flist.f
src/lz_pack_pkg.sv
src/sym_fifo.sv
src/lz_packer.sv
src/frame_buf.sv
src/lz_pack_top.sv
tb/tb_lz_pack.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the packer testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wall \
   -f flist.f \
   --top-module tb_lz_pack \
   -o sim_lz_pack

./obj_dir/sim_lz_pack | tee sim.log

# Pass or fail comes from the log
if grep -q "Test passed" sim.log; then
   exit 0
else
   exit 1
fi

//--- src/frame_buf.sv
/*
 * Output frame buffer of the packer stage.
 * Accepts every frame offered by the packer; the registered afull flag
 * stops the packer early enough that the buffer never overflows.
 * Frames leave on a valid/ready port in the order they came in.
 */

`timescale 1ns/1ps

module frame_buf (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   frm_valid,
   input  lz_pack_pkg::lz_frame_t frm_data,
   output logic                   afull,
   output logic                   out_valid,
   input  logic                   out_ready,
   output lz_pack_pkg::lz_frame_t out_data
);

   lz_pack_pkg::lz_frame_t mem [0:lz_pack_pkg::FRAME_BUF_DEPTH-1];

   logic [$clog2(lz_pack_pkg::FRAME_BUF_DEPTH)-1:0] wptr;
   logic [$clog2(lz_pack_pkg::FRAME_BUF_DEPTH)-1:0] rptr;
   logic [$clog2(lz_pack_pkg::FRAME_BUF_DEPTH):0]   count;
   logic [$clog2(lz_pack_pkg::FRAME_BUF_DEPTH):0]   count_nxt;

   logic pop;

   assign out_valid = (count != '0);
   assign out_data  = mem[rptr];
   assign pop       = out_valid && out_ready;

   always_comb begin
      count_nxt = count;
      if (frm_valid && !pop) begin
         count_nxt = count + 1'b1;
      end else if (pop && !frm_valid) begin
         count_nxt = count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (frm_valid) begin
         mem[wptr] <= frm_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
         afull <= 1'b0;
      end else begin
         if (frm_valid) begin
            wptr <= wptr + 1'b1;
         end
         if (pop) begin
            rptr <= rptr + 1'b1;
         end
         count <= count_nxt;
         afull <= (count_nxt >= lz_pack_pkg::FRAME_BUF_AFULL);   // Tracks the new fill level
      end
   end

endmodule

//--- src/lz_pack_pkg.sv
/*
 * Shared definitions for the LZ77 symbol packer stage.
 * Holds the symbol slot codes, the tokenizer entry layout, the output
 * frame layout and the buffer depths. Modules refer to these by
 * scoped name (lz_pack_pkg::name).
 */

package lz_pack_pkg;

   // Kind of symbol held in one entry slot
   typedef enum logic [1:0] {
      NONE = 2'd0,
      LIT  = 2'd1,
      PTR  = 2'd2,
      MTF  = 2'd3
   } sym_type_t;

   // One tokenizer entry, up to five symbols
   typedef struct packed {
      sym_type_t [4:0]  sym_type;   // Slot 0 is packed first
      logic [3:0][7:0]  literal;    // literal[0] goes to the first LIT slot
      logic [15:0]      offset;     // Shared by the single PTR/MTF slot
      logic [7:0]       length;
      logic             eot;        // Last entry of the block
   } sym_entry_t;

   // One packed output frame of four byte lanes
   typedef struct packed {
      logic [7:0] data0;
      logic [7:0] data1;
      logic [7:0] data2;
      logic [7:0] data3;
      logic [2:0] framing;          // Lanes used, 0 to 4
      logic       backref;
      logic       backref_type;     // 1 for MTF
      logic [1:0] backref_lane;     // Lane holding the offset LSB
      logic [7:0] offset_msb;
      logic [7:0] length;
      logic       eot;
   } lz_frame_t;

   // Entries held ahead of the packer
   localparam int SYM_FIFO_DEPTH = 4;

   // Output frame buffer depth
   localparam int FRAME_BUF_DEPTH = 8;

   // Fill level where the buffer throttles the packer
   // Leaves room for frames already on their way
   localparam int FRAME_BUF_AFULL = 6;

   // Rotating frame stages inside the packer
   localparam int STAGE_DEPTH = 4;

endpackage

//--- src/lz_pack_top.sv
/*
 * Top level of the LZ77 symbol packer stage.
 * Entries enter the symbol FIFO, the packer turns them into frames and
 * the frame buffer presents them on a valid/ready output.
 */

`timescale 1ns/1ps

module lz_pack_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    start,
   input  logic                    in_valid,
   output logic                    in_ready,
   input  lz_pack_pkg::sym_entry_t in_data,
   output logic                    out_valid,
   input  logic                    out_ready,
   output lz_pack_pkg::lz_frame_t  out_data
);

   logic                    fifo_empty;
   logic                    fifo_ren;
   lz_pack_pkg::sym_entry_t fifo_rdata;
   logic                    frm_valid;
   lz_pack_pkg::lz_frame_t  frm_data;
   logic                    buf_afull;

   sym_fifo u_sym_fifo (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_valid (in_valid),
      .wr_ready (in_ready),
      .wr_data  (in_data),
      .empty    (fifo_empty),
      .rdata    (fifo_rdata),
      .ren      (fifo_ren)
   );

   lz_packer u_lz_packer (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .empty     (fifo_empty),
      .rdata     (fifo_rdata),
      .ren       (fifo_ren),
      .frm_valid (frm_valid),
      .frm_data  (frm_data),
      .afull     (buf_afull)
   );

   frame_buf u_frame_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .frm_valid (frm_valid),
      .frm_data  (frm_data),
      .afull     (buf_afull),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

endmodule

//--- src/lz_packer.sv
/*
 * Packs entry symbols into 4-lane frames for the LZ77 compressor.
 * Each read places all five slots of one entry into a rotating set of
 * staged frames. Closed frames are sent in order, one per cycle, while
 * the frame buffer is not almost full. A start pulse opens a block and
 * the entry with eot closes it with an empty eot frame.
 */

`timescale 1ns/1ps

module lz_packer (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    start,
   input  logic                    empty,
   input  lz_pack_pkg::sym_entry_t rdata,
   output logic                    ren,
   output logic                    frm_valid,
   output lz_pack_pkg::lz_frame_t  frm_data,
   input  logic                    afull
);

   lz_pack_pkg::lz_frame_t stage_q [0:lz_pack_pkg::STAGE_DEPTH-1];
   lz_pack_pkg::lz_frame_t stage_c [0:lz_pack_pkg::STAGE_DEPTH-1];

   logic [$clog2(lz_pack_pkg::STAGE_DEPTH)-1:0] stg;      // Stage being filled
   logic [$clog2(lz_pack_pkg::STAGE_DEPTH)-1:0] stg_c;
   logic [$clog2(lz_pack_pkg::STAGE_DEPTH)-1:0] sel;      // Next stage to send
   logic [1:0]                                  lane;
   logic [1:0]                                  lane_c;
   logic                                        ptr_flag; // Current frame has a backref
   logic                                        ptr_c;
   logic [2:0]                                  occ;      // Closed frames not yet sent
   logic [2:0]                                  closes;
   logic [1:0]                                  lit_idx;
   logic                                        go;
   logic                                        done_c;
   logic                                        send;
   logic [lz_pack_pkg::STAGE_DEPTH-1:0]         stage_clr;

   // Write one byte into the given lane of a frame
   function automatic lz_pack_pkg::lz_frame_t put_byte(input lz_pack_pkg::lz_frame_t f,
                                                       input logic [1:0] lane_sel,
                                                       input logic [7:0] b);
      lz_pack_pkg::lz_frame_t r;
      r = f;
      case (lane_sel)
         2'd0: r.data0 = b;
         2'd1: r.data1 = b;
         2'd2: r.data2 = b;
         default: r.data3 = b;
      endcase
      return r;
   endfunction

   // Send side
   assign send     = (occ != 3'd0) && !afull;
   assign frm_valid = send;
   assign frm_data = stage_q[sel];

   always_comb begin
      for (int s = 0; s < lz_pack_pkg::STAGE_DEPTH; s++) begin
         stage_clr[s] = send && (sel == s);
      end
   end

   // Placement of one entry
   always_comb begin
      lane_c  = lane;
      stg_c   = stg;
      ptr_c   = ptr_flag;
      lit_idx = 2'd0;
      closes  = 3'd0;
      done_c  = 1'b0;
      ren     = 1'b0;

      // A stage sent this cycle starts over empty
      for (int s = 0; s < lz_pack_pkg::STAGE_DEPTH; s++) begin
         stage_c[s] = stage_clr[s] ? '0 : stage_q[s];
      end

      if (go && !empty && (occ < 3'd2)) begin
         ren = 1'b1;

         for (int k = 0; k < 5; k++) begin
            case (rdata.sym_type[k])
               lz_pack_pkg::LIT: begin
                  stage_c[stg_c] = put_byte(stage_c[stg_c], lane_c, rdata.literal[lit_idx]);
                  lit_idx = lit_idx + 2'd1;
               end
               lz_pack_pkg::PTR, lz_pack_pkg::MTF: begin
                  // Only one backref per frame
                  if (ptr_c) begin
                     stg_c  = stg_c + 1'b1;
                     lane_c = 2'd0;
                     closes = closes + 3'd1;
                  end
                  stage_c[stg_c] = put_byte(stage_c[stg_c], lane_c, rdata.offset[7:0]);
                  stage_c[stg_c].backref      = 1'b1;
                  stage_c[stg_c].backref_type = (rdata.sym_type[k] == lz_pack_pkg::MTF);
                  stage_c[stg_c].backref_lane = lane_c;
                  stage_c[stg_c].offset_msb   = rdata.offset[15:8];
                  stage_c[stg_c].length       = rdata.length;
                  ptr_c = 1'b1;
               end
               default: ;
            endcase

            if (rdata.sym_type[k] != lz_pack_pkg::NONE) begin
               stage_c[stg_c].framing = stage_c[stg_c].framing + 3'd1;
               if (lane_c == 2'd3) begin   // Frame full
                  stg_c  = stg_c + 1'b1;
                  closes = closes + 3'd1;
                  ptr_c  = 1'b0;
               end
               lane_c = lane_c + 2'd1;
            end
         end

         if (rdata.eot) begin
            done_c = 1'b1;
            ptr_c  = 1'b0;
            // Partial frame closes before the eot frame
            if (lane_c != 2'd0) begin
               stg_c  = stg_c + 1'b1;
               lane_c = 2'd0;
               closes = closes + 3'd1;
            end
            stage_c[stg_c].eot = 1'b1;
            stg_c  = stg_c + 1'b1;
            closes = closes + 3'd1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int s = 0; s < lz_pack_pkg::STAGE_DEPTH; s++) begin
            stage_q[s] <= '0;
         end
         stg      <= '0;
         sel      <= '0;
         lane     <= 2'd0;
         ptr_flag <= 1'b0;
         occ      <= 3'd0;
         go       <= 1'b0;
      end else begin
         for (int s = 0; s < lz_pack_pkg::STAGE_DEPTH; s++) begin
            stage_q[s] <= stage_c[s];
         end
         if (start) begin
            stg      <= '0;
            sel      <= '0;
            lane     <= 2'd0;
            ptr_flag <= 1'b0;
            occ      <= 3'd0;
            go       <= 1'b1;
         end else begin
            stg      <= stg_c;
            lane     <= lane_c;
            ptr_flag <= ptr_c;
            occ      <= occ + closes - {2'b00, send};
            if (send) begin
               sel <= sel + 1'b1;
            end
            if (done_c) begin
               go <= 1'b0;   // Block finished
            end
         end
      end
   end

endmodule

//--- src/sym_fifo.sv
/*
 * Symbol entry FIFO between the tokenizer and the packer.
 * Write side is valid/ready; a transfer happens when both are high.
 * Read side shows the head entry combinationally and pops it on a
 * clock edge with ren high. ren must not be raised while empty.
 */

`timescale 1ns/1ps

module sym_fifo (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    wr_valid,
   output logic                    wr_ready,
   input  lz_pack_pkg::sym_entry_t wr_data,
   output logic                    empty,
   output lz_pack_pkg::sym_entry_t rdata,
   input  logic                    ren
);

   lz_pack_pkg::sym_entry_t mem [0:lz_pack_pkg::SYM_FIFO_DEPTH-1];

   logic [$clog2(lz_pack_pkg::SYM_FIFO_DEPTH)-1:0] wptr;
   logic [$clog2(lz_pack_pkg::SYM_FIFO_DEPTH)-1:0] rptr;
   logic [$clog2(lz_pack_pkg::SYM_FIFO_DEPTH):0]   count;

   logic push;
   logic pop;

   assign wr_ready = (count != lz_pack_pkg::SYM_FIFO_DEPTH);
   assign empty    = (count == '0);
   assign rdata    = mem[rptr];   // Head is visible without a read

   assign push = wr_valid && wr_ready;
   assign pop  = ren && !empty;

   // Entry storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wptr] <= wr_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wptr <= wptr + 1'b1;   // Depth is a power of two
         end
         if (pop) begin
            rptr <= rptr + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- tb/tb_lz_pack.sv
/*
 * Testbench for the LZ77 symbol packer stage.
 * Each directed test opens a block with start, feeds entries through the
 * valid/ready input, collects frames up to the eot frame and compares them
 * with a reference packing model. Run through flist.f.
 */

`timescale 1ns/1ps

module tb_lz_pack;

   logic                    clk;
   logic                    rst_n;
   logic                    start;
   logic                    in_valid;
   logic                    in_ready;
   lz_pack_pkg::sym_entry_t in_data;
   logic                    out_valid;
   logic                    out_ready;
   lz_pack_pkg::lz_frame_t  out_data;

   lz_pack_pkg::sym_entry_t ent_q [$];
   lz_pack_pkg::lz_frame_t  exp_q [$];
   lz_pack_pkg::lz_frame_t  got_q [$];

   int    cycles;
   int    errors;
   int    n_pass;
   int    n_fail;
   bit    saw_stall;
   bit    seen_early;

   lz_pack_top uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Run limit, well above the six tests with stalls
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= 4000) begin
         $display("Run stopped after %0d cycles without finishing", cycles);
         $display("Test failed");
         $finish;
      end
   end

   // types holds slot k in bits 2k+1:2k
   function automatic lz_pack_pkg::sym_entry_t make_entry(input logic [9:0] types,
                                                          input logic [31:0] lits,
                                                          input logic [15:0] offs,
                                                          input logic [7:0] len,
                                                          input logic eot);
      lz_pack_pkg::sym_entry_t e;
      e = '0;
      for (int k = 0; k < 5; k++) begin
         e.sym_type[k] = lz_pack_pkg::sym_type_t'(types[2*k +: 2]);
      end
      for (int b = 0; b < 4; b++) begin
         e.literal[b] = lits[8*b +: 8];   // Byte 0 is the first literal
      end
      e.offset = offs;
      e.length = len;
      e.eot    = eot;
      return e;
   endfunction

   // Reference packing model over ent_q
   function automatic void build_expected();
      lz_pack_pkg::lz_frame_t f;
      logic [7:0] b;
      int lane;
      int li;
      bit has_ptr;
      f = '0;
      lane = 0;
      has_ptr = 0;
      exp_q.delete();
      foreach (ent_q[i]) begin
         li = 0;
         for (int k = 0; k < 5; k++) begin
            if (ent_q[i].sym_type[k] == lz_pack_pkg::NONE) continue;
            if (ent_q[i].sym_type[k] == lz_pack_pkg::LIT) begin
               b = ent_q[i].literal[li];
               li++;
            end else begin
               if (has_ptr) begin   // Second backref needs a fresh frame
                  exp_q.push_back(f);
                  f = '0;
                  lane = 0;
               end
               b = ent_q[i].offset[7:0];
               f.backref      = 1'b1;
               f.backref_type = (ent_q[i].sym_type[k] == lz_pack_pkg::MTF);
               f.backref_lane = lane[1:0];
               f.offset_msb   = ent_q[i].offset[15:8];
               f.length       = ent_q[i].length;
               has_ptr = 1;
            end
            case (lane)
               0: f.data0 = b;
               1: f.data1 = b;
               2: f.data2 = b;
               default: f.data3 = b;
            endcase
            f.framing = f.framing + 3'd1;
            if (lane == 3) begin
               exp_q.push_back(f);
               f = '0;
               lane = 0;
               has_ptr = 0;
            end else begin
               lane++;
            end
         end
         if (ent_q[i].eot) begin
            if (lane != 0) exp_q.push_back(f);
            if (lane != 0) f = '0;
            f.eot = 1'b1;
            exp_q.push_back(f);
            f = '0;
            lane = 0;
            has_ptr = 0;
         end
      end
   endfunction

   task automatic check_field(input string name, input logic [15:0] exp, input logic [15:0] act,
                              input int idx);
      if (exp !== act) begin
         $display("** Error frame %0d %s expected %h got %h", idx, name, exp, act);
         errors++;
      end
   endtask

   task automatic compare_frames();
      int n;
      n = (exp_q.size() < got_q.size()) ? exp_q.size() : got_q.size();
      if (got_q.size() < exp_q.size()) begin
         $display("Missing frames, expected %0d but got %0d", exp_q.size(), got_q.size());
         errors++;
      end else if (got_q.size() > exp_q.size()) begin
         $display("Extra frames, expected %0d but got %0d", exp_q.size(), got_q.size());
         errors++;
      end
      for (int i = 0; i < n; i++) begin
         check_field("data0", exp_q[i].data0, got_q[i].data0, i);
         check_field("data1", exp_q[i].data1, got_q[i].data1, i);
         check_field("data2", exp_q[i].data2, got_q[i].data2, i);
         check_field("data3", exp_q[i].data3, got_q[i].data3, i);
         check_field("framing", exp_q[i].framing, got_q[i].framing, i);
         check_field("backref", exp_q[i].backref, got_q[i].backref, i);
         check_field("backref_type", exp_q[i].backref_type, got_q[i].backref_type, i);
         check_field("backref_lane", exp_q[i].backref_lane, got_q[i].backref_lane, i);
         check_field("offset_msb", exp_q[i].offset_msb, got_q[i].offset_msb, i);
         check_field("length", exp_q[i].length, got_q[i].length, i);
         check_field("eot", exp_q[i].eot, got_q[i].eot, i);
      end
   endtask

   // Opens a block, feeds ent_q unless already loaded, collects to eot
   task automatic run_block(input bit drive, input bit rnd);
      bit done;
      bit took;
      int hold;
      done = 0;
      took = 0;
      hold = 0;
      got_q.delete();
      build_expected();
      fork
         begin
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            if (drive) begin
               foreach (ent_q[i]) begin
                  in_valid <= 1'b1;
                  in_data  <= ent_q[i];
                  // in_ready is stable between edges
                  do begin
                     @(negedge clk);
                     took = in_ready;
                     @(posedge clk);
                  end while (!took);
               end
               in_valid <= 1'b0;
            end
         end
         begin
            while (!done) begin
               @(negedge clk);
               if (out_valid && out_ready) begin
                  got_q.push_back(out_data);
                  if (out_data.eot) done = 1;
               end
               if (!in_ready) saw_stall = 1;
               @(posedge clk);
               hold++;
               if (rnd) out_ready <= (hold > 40) && (($urandom % 10) >= 3);  // Long stall first
            end
            out_ready <= 1'b1;
         end
      join
      repeat (10) begin
         @(negedge clk);
         if (out_valid) begin
            $display("Extra frame after the eot frame");
            errors++;
         end
      end
      compare_frames();
   endtask

   task automatic report(input string name);
      if (errors == 0) begin
         $display("%s: ok", name);
         n_pass++;
      end else begin
         $display("%s: %0d errors", name, errors);
         n_fail++;
      end
      errors = 0;
   endtask

   task automatic idle_until_start();
      ent_q.delete();
      ent_q.push_back(make_entry(10'b00_00_01_01_01, 32'h0033_2211, 16'h0, 8'h0, 1'b1));
      if (!in_ready) begin
         $display("in_ready is low after reset");
         errors++;
      end
      @(posedge clk);
      in_valid <= 1'b1;
      in_data  <= ent_q[0];
      @(posedge clk);
      in_valid <= 1'b0;
      repeat (20) begin
         @(negedge clk);
         if (out_valid) seen_early = 1;
      end
      if (seen_early) begin
         $display("A frame appeared before start");
         errors++;
      end
      run_block(1'b0, 1'b0);
      report("idle_until_start");
   endtask

   task automatic literal_frames();
      ent_q.delete();
      ent_q.push_back(make_entry(10'b00_01_01_01_01, 32'h4433_2211, 16'h0, 8'h0, 1'b0));
      ent_q.push_back(make_entry(10'b00_01_00_01_01, 32'h0077_6655, 16'h0, 8'h0, 1'b0));
      ent_q.push_back(make_entry(10'b00_00_01_01_00, 32'h0000_9988, 16'h0, 8'h0, 1'b1));
      run_block(1'b1, 1'b0);
      ent_q.delete();
      ent_q.push_back(make_entry(10'b01_01_01_01_00, 32'hddcc_bbaa, 16'h0, 8'h0, 1'b1));
      run_block(1'b1, 1'b0);
      report("literals");
   endtask

   task automatic backref_lanes();
      logic [9:0] t;
      for (int ty = 2; ty <= 3; ty++) begin
         for (int ln = 0; ln < 4; ln++) begin
            t = '0;
            for (int k = 0; k < ln; k++) t[2*k +: 2] = 2'd1;
            t[2*ln +: 2] = ty[1:0];
            ent_q.delete();
            ent_q.push_back(make_entry(t, 32'h5a4b_3c2d, 16'hbe00 + 16'(ln * 17 + ty),
                                       8'(8'h20 + ln), 1'b1));
            run_block(1'b1, 1'b0);
         end
      end
      report("backref_lanes");
   endtask

   task automatic two_backrefs();
      ent_q.delete();
      ent_q.push_back(make_entry(10'b00_00_00_10_01, 32'h0000_00a1, 16'h1234, 8'h05, 1'b0));
      ent_q.push_back(make_entry(10'b00_00_00_11_01, 32'h0000_00b2, 16'h5678, 8'h09, 1'b1));
      run_block(1'b1, 1'b0);
      report("two_backrefs");
   endtask

   task automatic random_block(input int n_ent);
      logic [9:0] t;
      int nl;
      bit np;
      int r;
      ent_q.delete();
      for (int i = 0; i < n_ent; i++) begin
         t = '0;
         nl = 0;
         np = 0;
         for (int k = 0; k < 5; k++) begin
            r = $urandom % 4;
            if (r == 1 && nl < 4) nl++;
            else if (r >= 2 && !np) np = 1;
            else r = 0;   // No room for that kind
            t[2*k +: 2] = r[1:0];
         end
         ent_q.push_back(make_entry(t, $urandom, 16'($urandom), 8'($urandom),
                                    i == n_ent - 1));
      end
   endtask

   task automatic backpressure();
      saw_stall = 0;
      random_block(40);
      run_block(1'b1, 1'b1);
      if (!saw_stall) begin
         $display("in_ready never fell under back-pressure");
         errors++;
      end
      report("backpressure");
   endtask

   task automatic two_blocks();
      ent_q.delete();
      ent_q.push_back(make_entry(10'b00_00_10_01_01, 32'h0000_0201, 16'hc0de, 8'h11, 1'b1));
      run_block(1'b1, 1'b0);
      random_block(12);
      run_block(1'b1, 1'b0);
      report("two_blocks");
   endtask

   initial begin
      void'($urandom(32'h474a_2d78));
      rst_n = 1'b0;
      start = 1'b0;
      in_valid = 1'b0;
      in_data = '0;
      out_ready = 1'b1;
      cycles = 0;
      errors = 0;
      n_pass = 0;
      n_fail = 0;
      saw_stall = 0;
      seen_early = 0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      idle_until_start();
      literal_frames();
      backref_lanes();
      two_backrefs();
      backpressure();
      two_blocks();
      $display("Tests passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
